//--- mag_pkg.sv
`default_nettype none

package mag_pkg;

  ////////////////////////////////////////
  // fixed-point word
  ////////////////////////////////////////

  localparam int DATA_W = 32;

  typedef logic signed [DATA_W-1:0] fx_t;  // binary point set by FRAC_W

  localparam fx_t FX_MAX = {1'b0, {(DATA_W-1){1'b1}}};
  localparam fx_t FX_MIN = {1'b1, {(DATA_W-1){1'b0}}};

  ////////////////////////////////////////
  // vectors, matrix, request
  ////////////////////////////////////////

  typedef struct packed {
    fx_t x;
    fx_t y;
    fx_t z;
  } vec3_t;

  typedef struct packed {
    fx_t c11;
    fx_t c12;
    fx_t c13;
    fx_t c21;
    fx_t c22;
    fx_t c23;
    fx_t c31;
    fx_t c32;
    fx_t c33;
  } dcm_t;

  typedef struct packed {
    vec3_t mag;  // raw magnetometer sample
    dcm_t  dcm;  // body to earth rotation
  } mag_req_t;

  ////////////////////////////////////////
  // MAC command
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    MAC_LOAD,  // start a new sum
    MAC_ADD,
    MAC_SUB
  } mac_op_e;

  typedef struct packed {
    mac_op_e op;
    fx_t     a;
    fx_t     b;
    logic    last;  // final term of the group
  } mac_cmd_t;

  // sequencer steps, in the order they are walked
  typedef enum logic [3:0] {
    IDLE,
    SQ_SUM,
    NORM_ROOT,
    NORM_DIV_X,
    NORM_DIV_Y,
    NORM_DIV_Z,
    ROT_H,
    BX_SUM,
    BX_ROOT,
    ROT_W,
    CROSS,
    DONE
  } step_e;

endpackage

`default_nettype wire

//--- fx_mac.sv
`default_nettype none

module fx_mac import mag_pkg::*; #(
  parameter int FRAC_W = 16
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     cmd_valid,
  input  mac_cmd_t cmd,
  output logic     acc_valid,
  output fx_t      acc
);

  localparam int PROD_W = 2 * DATA_W;
  localparam int ACC_W  = PROD_W + 4;  // headroom for a few terms

  localparam logic signed [ACC_W-1:0] SAT_HI = ACC_W'(FX_MAX);
  localparam logic signed [ACC_W-1:0] SAT_LO = ACC_W'(FX_MIN);

  logic signed [PROD_W-1:0] prod_full;
  logic                     s1_valid;
  mac_op_e                  s1_op;
  logic                     s1_last;
  logic signed [PROD_W-1:0] s1_prod;
  logic signed [ACC_W-1:0]  acc_r;
  logic signed [ACC_W-1:0]  sum_nxt;
  fx_t                      sum_sat;

  assign prod_full = $signed(cmd.a) * $signed(cmd.b);

  always_comb begin
    case (s1_op)
      MAC_ADD: sum_nxt = acc_r + s1_prod;
      MAC_SUB: sum_nxt = acc_r - s1_prod;
      default: sum_nxt = ACC_W'(s1_prod);  // load
    endcase
  end

  // clamp once at the end of the group
  always_comb begin
    if (sum_nxt > SAT_HI)
      sum_sat = FX_MAX;
    else if (sum_nxt < SAT_LO)
      sum_sat = FX_MIN;
    else
      sum_sat = sum_nxt[DATA_W-1:0];
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      s1_valid  <= 1'b0;
      acc_valid <= 1'b0;
    end else begin
      s1_valid  <= cmd_valid;
      acc_valid <= s1_valid && s1_last;  // group result out
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) begin  // stage one
      s1_op   <= cmd.op;
      s1_last <= cmd.last;
      s1_prod <= prod_full >>> FRAC_W;
    end
    if (s1_valid) begin  // stage two
      acc_r <= sum_nxt;
      if (s1_last)
        acc <= sum_sat;
    end
  end

endmodule

`default_nettype wire

//--- fx_sqrt.sv
`default_nettype none

module fx_sqrt import mag_pkg::*; #(
  parameter int FRAC_W = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  fx_t  in,
  output logic done,
  output fx_t  out
);

  localparam int RAD_W  = 2 * ((DATA_W + FRAC_W + 1) / 2);  // even radicand width
  localparam int ROOT_W = RAD_W / 2;
  localparam int REM_W  = ROOT_W + 3;
  localparam int CNT_W  = $clog2(ROOT_W + 1);

  logic              busy;
  logic [CNT_W-1:0]  cnt;
  logic [RAD_W-1:0]  rad;
  logic [REM_W-1:0]  rem;
  logic [ROOT_W-1:0] root;
  logic [REM_W-1:0]  rem_sh;
  logic [REM_W-1:0]  trial;
  logic              fits;

  assign rem_sh = {rem[REM_W-3:0], rad[RAD_W-1 -: 2]};  // bring in next bit pair
  assign trial  = REM_W'({root, 2'b01});                 // 4q + 1
  assign fits   = rem_sh >= trial;
  assign out    = fx_t'(root);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(ROOT_W);
      end else if (busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_W'(1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      rad  <= RAD_W'({in, {FRAC_W{1'b0}}});  // operand scaled up by FRAC_W
      rem  <= '0;
      root <= '0;
    end else if (busy) begin
      rad  <= rad << 2;
      rem  <= fits ? rem_sh - trial : rem_sh;
      root <= {root[ROOT_W-2:0], fits};
    end
  end

endmodule

`default_nettype wire

//--- fx_div.sv
`default_nettype none

module fx_div import mag_pkg::*; #(
  parameter int FRAC_W = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  fx_t  num,
  input  fx_t  den,
  output logic done,
  output fx_t  out
);

  localparam int DIV_W = DATA_W + FRAC_W;  // scaled dividend width
  localparam int CNT_W = $clog2(DIV_W + 1);

  localparam logic [DIV_W-1:0] MAG_POS = DIV_W'({1'b0, {(DATA_W-1){1'b1}}});
  localparam logic [DIV_W-1:0] MAG_NEG = MAG_POS + 1'b1;

  logic              busy;
  logic [CNT_W-1:0]  cnt;
  logic              neg;
  logic [DIV_W-1:0]  dvd;
  logic [DATA_W-1:0] den_mag;
  logic [DATA_W:0]   rem;
  logic [DIV_W-1:0]  quo;
  logic [DATA_W-1:0] num_abs;
  logic [DATA_W-1:0] den_abs;
  logic [DATA_W:0]   rem_sh;
  logic              ge;
  logic [DATA_W:0]   rem_nxt;
  logic [DIV_W-1:0]  quo_nxt;
  logic [DATA_W-1:0] q_lo;
  fx_t               res_sat;
  logic              fin_zero;
  logic              fin_iter;

  assign num_abs = num[DATA_W-1] ? -num : num;
  assign den_abs = den[DATA_W-1] ? -den : den;

  // one restoring step
  assign rem_sh  = {rem[DATA_W-1:0], dvd[DIV_W-1]};
  assign ge      = rem_sh >= {1'b0, den_mag};
  assign rem_nxt = ge ? rem_sh - {1'b0, den_mag} : rem_sh;
  assign quo_nxt = {quo[DIV_W-2:0], ge};
  assign q_lo    = quo_nxt[DATA_W-1:0];

  assign fin_zero = start && (den == '0);
  assign fin_iter = busy && (cnt == CNT_W'(1));

  always_comb begin
    if (neg)
      res_sat = (quo_nxt > MAG_NEG) ? FX_MIN : -q_lo;
    else
      res_sat = (quo_nxt > MAG_POS) ? FX_MAX : q_lo;
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= fin_zero || fin_iter;
      if (start && !fin_zero) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(DIV_W);
      end else if (busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_W'(1))
          busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      dvd     <= {num_abs, {FRAC_W{1'b0}}};
      den_mag <= den_abs;
      rem     <= '0;
      quo     <= '0;
      neg     <= num[DATA_W-1] ^ den[DATA_W-1];  // sign of the quotient
    end else if (busy) begin
      dvd <= dvd << 1;
      rem <= rem_nxt;
      quo <= quo_nxt;
    end

    if (fin_zero)
      out <= num[DATA_W-1] ? FX_MIN : FX_MAX;  // x/0 pins to the rail
    else if (fin_iter)
      out <= res_sat;
  end

endmodule

`default_nettype wire

//--- mag_error_ctrl.sv
`default_nettype none

module mag_error_ctrl import mag_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid,
  output logic     req_ready,
  input  mag_req_t req,
  output logic     err_valid,
  input  logic     err_ready,
  output vec3_t    err,
  output logic     cmd_valid,
  output mac_cmd_t cmd,
  input  logic     acc_valid,
  input  fx_t      acc,
  output logic     sqrt_start,
  output fx_t      sqrt_in,
  input  logic     sqrt_done,
  input  fx_t      sqrt_out,
  output logic     div_start,
  output fx_t      div_num,
  output fx_t      div_den,
  input  logic     div_done,
  input  fx_t      div_out
);

  step_e      step;
  step_e      step_nxt;
  logic [3:0] idx;      // next term to issue
  logic [1:0] rcv;      // groups returned in this step
  mac_cmd_t   term;
  logic [3:0] n_terms;
  logic       issuing;
  logic       grp_last;
  logic       sqrt_go;
  logic       div_go;
  vec3_t      m_r;
  dcm_t       c_r;
  vec3_t      n;        // normalized sample
  fx_t        hx;
  fx_t        hy;
  fx_t        bz;
  fx_t        bx;
  vec3_t      w;

  function automatic mac_cmd_t mk(mac_op_e op, fx_t a, fx_t b, logic last);
    mac_cmd_t c;
    c.op   = op;
    c.a    = a;
    c.b    = b;
    c.last = last;
    return c;
  endfunction

  assign req_ready = (step == IDLE);
  assign err_valid = (step == DONE);
  assign issuing   = idx < n_terms;
  assign grp_last  = (rcv == 2'd2);  // multi-group steps carry three groups
  assign sqrt_go   = acc_valid && (step == SQ_SUM || step == BX_SUM);
  assign div_go    = (step == NORM_ROOT && sqrt_done) ||
                     (div_done && (step == NORM_DIV_X || step == NORM_DIV_Y));

  ////////////////////////////////////////
  // MAC term table
  ////////////////////////////////////////

  always_comb begin
    term    = mk(MAC_LOAD, '0, '0, 1'b0);
    n_terms = 4'd0;
    case (step)
      SQ_SUM: begin  // |m|^2
        n_terms = 4'd3;
        case (idx)
          4'd0:    term = mk(MAC_LOAD, m_r.x, m_r.x, 1'b0);
          4'd1:    term = mk(MAC_ADD,  m_r.y, m_r.y, 1'b0);
          default: term = mk(MAC_ADD,  m_r.z, m_r.z, 1'b1);
        endcase
      end
      ROT_H: begin  // hx, hy, bz from the three columns
        n_terms = 4'd9;
        case (idx)
          4'd0:    term = mk(MAC_LOAD, n.x, c_r.c11, 1'b0);
          4'd1:    term = mk(MAC_ADD,  n.y, c_r.c21, 1'b0);
          4'd2:    term = mk(MAC_ADD,  n.z, c_r.c31, 1'b1);
          4'd3:    term = mk(MAC_LOAD, n.x, c_r.c12, 1'b0);
          4'd4:    term = mk(MAC_ADD,  n.y, c_r.c22, 1'b0);
          4'd5:    term = mk(MAC_ADD,  n.z, c_r.c32, 1'b1);
          4'd6:    term = mk(MAC_LOAD, n.x, c_r.c13, 1'b0);
          4'd7:    term = mk(MAC_ADD,  n.y, c_r.c23, 1'b0);
          default: term = mk(MAC_ADD,  n.z, c_r.c33, 1'b1);
        endcase
      end
      BX_SUM: begin
        n_terms = 4'd2;
        case (idx)
          4'd0:    term = mk(MAC_LOAD, hx, hx, 1'b0);
          default: term = mk(MAC_ADD,  hy, hy, 1'b1);
        endcase
      end
      ROT_W: begin  // reference field back to body frame
        n_terms = 4'd6;
        case (idx)
          4'd0:    term = mk(MAC_LOAD, bx, c_r.c11, 1'b0);
          4'd1:    term = mk(MAC_ADD,  bz, c_r.c13, 1'b1);
          4'd2:    term = mk(MAC_LOAD, bx, c_r.c21, 1'b0);
          4'd3:    term = mk(MAC_ADD,  bz, c_r.c23, 1'b1);
          4'd4:    term = mk(MAC_LOAD, bx, c_r.c31, 1'b0);
          default: term = mk(MAC_ADD,  bz, c_r.c33, 1'b1);
        endcase
      end
      CROSS: begin  // n x w
        n_terms = 4'd6;
        case (idx)
          4'd0:    term = mk(MAC_LOAD, n.y, w.z, 1'b0);
          4'd1:    term = mk(MAC_SUB,  n.z, w.y, 1'b1);
          4'd2:    term = mk(MAC_LOAD, n.z, w.x, 1'b0);
          4'd3:    term = mk(MAC_SUB,  n.x, w.z, 1'b1);
          4'd4:    term = mk(MAC_LOAD, n.x, w.y, 1'b0);
          default: term = mk(MAC_SUB,  n.y, w.x, 1'b1);
        endcase
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // step sequencing
  ////////////////////////////////////////

  always_comb begin
    step_nxt = step;
    case (step)
      IDLE:       if (req_valid)             step_nxt = SQ_SUM;
      SQ_SUM:     if (acc_valid)             step_nxt = NORM_ROOT;
      NORM_ROOT:  if (sqrt_done)             step_nxt = NORM_DIV_X;
      NORM_DIV_X: if (div_done)              step_nxt = NORM_DIV_Y;
      NORM_DIV_Y: if (div_done)              step_nxt = NORM_DIV_Z;
      NORM_DIV_Z: if (div_done)              step_nxt = ROT_H;
      ROT_H:      if (acc_valid && grp_last) step_nxt = BX_SUM;
      BX_SUM:     if (acc_valid)             step_nxt = BX_ROOT;
      BX_ROOT:    if (sqrt_done)             step_nxt = ROT_W;
      ROT_W:      if (acc_valid && grp_last) step_nxt = CROSS;
      CROSS:      if (acc_valid && grp_last) step_nxt = DONE;
      DONE:       if (err_ready)             step_nxt = IDLE;
      default:                               step_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      step       <= IDLE;
      idx        <= '0;
      rcv        <= '0;
      cmd_valid  <= 1'b0;
      sqrt_start <= 1'b0;
      div_start  <= 1'b0;
    end else begin
      step       <= step_nxt;
      cmd_valid  <= issuing;
      sqrt_start <= sqrt_go;
      div_start  <= div_go;
      if (step_nxt != step) begin  // fresh counters per step
        idx <= '0;
        rcv <= '0;
      end else begin
        if (issuing)
          idx <= idx + 4'd1;
        if (acc_valid)
          rcv <= rcv + 2'd1;
      end
    end
  end

  ////////////////////////////////////////
  // operands and intermediates
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (step == IDLE && req_valid) begin
      m_r <= req.mag;
      c_r <= req.dcm;
    end
    if (issuing)
      cmd <= term;
    if (sqrt_go)
      sqrt_in <= acc;

    if (step == NORM_ROOT && sqrt_done) begin
      div_num <= m_r.y;     // n.x = my / |m|
      div_den <= sqrt_out;  // |m| kept for all three divides
    end
    if (step == NORM_DIV_X && div_done) begin
      n.x     <= div_out;
      div_num <= -m_r.x;    // n.y = -mx / |m|
    end
    if (step == NORM_DIV_Y && div_done) begin
      n.y     <= div_out;
      div_num <= m_r.z;
    end
    if (step == NORM_DIV_Z && div_done)
      n.z <= div_out;
    if (step == BX_ROOT && sqrt_done)
      bx <= sqrt_out;

    if (acc_valid) begin
      case (step)
        ROT_H: begin
          case (rcv)
            2'd0:    hx <= acc;
            2'd1:    hy <= acc;
            default: bz <= acc;
          endcase
        end
        ROT_W: begin
          case (rcv)
            2'd0:    w.x <= acc;
            2'd1:    w.y <= acc;
            default: w.z <= acc;
          endcase
        end
        CROSS: begin  // held until the result handshake
          case (rcv)
            2'd0:    err.x <= acc;
            2'd1:    err.y <= acc;
            default: err.z <= acc;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- mag_error_top.sv
`default_nettype none

module mag_error_top import mag_pkg::*; #(
  parameter int FRAC_W = 16
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     req_valid,
  output logic     req_ready,
  input  mag_req_t req,
  output logic     err_valid,
  input  logic     err_ready,
  output vec3_t    err
);

  ////////////////////////////////////////
  // sequencer to datapath
  ////////////////////////////////////////

  logic     cmd_valid;
  mac_cmd_t cmd;
  logic     acc_valid;
  fx_t      acc;
  logic     sqrt_start;
  fx_t      sqrt_in;
  logic     sqrt_done;
  fx_t      sqrt_out;
  logic     div_start;
  fx_t      div_num;
  fx_t      div_den;
  logic     div_done;
  fx_t      div_out;

  mag_error_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .err_valid  (err_valid),
    .err_ready  (err_ready),
    .err        (err),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .acc_valid  (acc_valid),
    .acc        (acc),
    .sqrt_start (sqrt_start),
    .sqrt_in    (sqrt_in),
    .sqrt_done  (sqrt_done),
    .sqrt_out   (sqrt_out),
    .div_start  (div_start),
    .div_num    (div_num),
    .div_den    (div_den),
    .div_done   (div_done),
    .div_out    (div_out)
  );

  fx_mac #(.FRAC_W(FRAC_W)) u_mac (  // all dot products and cross terms
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .acc_valid (acc_valid),
    .acc       (acc)
  );

  fx_sqrt #(.FRAC_W(FRAC_W)) u_sqrt (  // |m| and bx
    .clk   (clk),
    .rst   (rst),
    .start (sqrt_start),
    .in    (sqrt_in),
    .done  (sqrt_done),
    .out   (sqrt_out)
  );

  fx_div #(.FRAC_W(FRAC_W)) u_div (  // sample normalization
    .clk   (clk),
    .rst   (rst),
    .start (div_start),
    .num   (div_num),
    .den   (div_den),
    .done  (div_done),
    .out   (div_out)
  );

endmodule

`default_nettype wire

//--- tb_mag_error.sv
`default_nettype none

module tb_mag_error
  import mag_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int  FRAC_W     = 16;
  localparam int  N_RAND     = 16;
  localparam int  MAX_CYCLES = 20 * 400;  // 20 requests of at most 400 cycles
  localparam fx_t ONE        = 32'sd1 <<< FRAC_W;

  logic        clk;
  logic        rst;
  logic        req_valid;
  logic        req_ready;
  mag_req_t    req;
  logic        err_valid;
  logic        err_ready;
  vec3_t       err;

  logic [31:0] lcg_state;
  string       test_name;
  vec3_t       exp_err;
  int          n_acc;
  int          n_res;
  int          n_sent;
  int          cycles = 0;

  mag_error_top #(.FRAC_W(FRAC_W)) dut (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .err_valid (err_valid),
    .err_ready (err_ready),
    .err       (err)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // run control
  ////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input vec3_t expected, input vec3_t actual);
    stop_run($sformatf("ERR %s: expected %h, actual %h", name, expected, actual));
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
      stop_run($sformatf("timeout: no end of run after %0d cycles", MAX_CYCLES));
  end

  // handshake counts
  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      n_acc <= 0;
      n_res <= 0;
    end else begin
      if (req_valid && req_ready)
        n_acc <= n_acc + 1;
      if (err_valid && err_ready)
        n_res <= n_res + 1;
    end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic longint fx_mul(fx_t a, fx_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return p >>> FRAC_W;  // floor of the scaled product
  endfunction

  function automatic fx_t clamp(longint s);
    if (s > longint'(FX_MAX))
      return FX_MAX;
    if (s < longint'(FX_MIN))
      return FX_MIN;
    return fx_t'(s);
  endfunction

  // largest r with r*r <= x << FRAC_W
  function automatic fx_t root(fx_t x);
    longint v;
    longint r;
    longint t;
    v = longint'(x) <<< FRAC_W;
    r = 0;
    for (int b = (DATA_W + FRAC_W) / 2 - 1; b >= 0; b--) begin
      t = r | (longint'(1) << b);
      if (t * t <= v)
        r = t;
    end
    return fx_t'(r);
  endfunction

  function automatic fx_t quot(fx_t num, fx_t den);
    longint q;
    if (den == 0)
      return (num < 0) ? FX_MIN : FX_MAX;
    q = (longint'(num) <<< FRAC_W) / longint'(den);  // truncates toward zero
    return clamp(q);
  endfunction

  function automatic vec3_t model(mag_req_t r);
    vec3_t m;
    dcm_t  c;
    fx_t   len;
    vec3_t n;
    fx_t   hx;
    fx_t   hy;
    fx_t   bz;
    fx_t   bx;
    vec3_t w;
    vec3_t e;
    m   = r.mag;
    c   = r.dcm;
    len = root(clamp(fx_mul(m.x, m.x) + fx_mul(m.y, m.y) + fx_mul(m.z, m.z)));
    n.x = quot(m.y, len);  // axis swap of the reference
    n.y = quot(-m.x, len);
    n.z = quot(m.z, len);
    hx  = clamp(fx_mul(n.x, c.c11) + fx_mul(n.y, c.c21) + fx_mul(n.z, c.c31));
    hy  = clamp(fx_mul(n.x, c.c12) + fx_mul(n.y, c.c22) + fx_mul(n.z, c.c32));
    bz  = clamp(fx_mul(n.x, c.c13) + fx_mul(n.y, c.c23) + fx_mul(n.z, c.c33));
    bx  = root(clamp(fx_mul(hx, hx) + fx_mul(hy, hy)));
    w.x = clamp(fx_mul(bx, c.c11) + fx_mul(bz, c.c13));
    w.y = clamp(fx_mul(bx, c.c21) + fx_mul(bz, c.c23));
    w.z = clamp(fx_mul(bx, c.c31) + fx_mul(bz, c.c33));
    e.x = clamp(fx_mul(n.y, w.z) - fx_mul(n.z, w.y));
    e.y = clamp(fx_mul(n.z, w.x) - fx_mul(n.x, w.z));
    e.z = clamp(fx_mul(n.x, w.y) - fx_mul(n.y, w.x));
    return e;
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  idle_after_reset: assert property (@(posedge clk) disable iff (!rst)
      $rose(rst) |-> (req_ready && !err_valid))
    else stop_run("DUT not idle with req_ready high after reset");

  result_value: assert property (@(posedge clk) disable iff (!rst)
      (err_valid && err_ready) |-> (err == exp_err))
    else report_mismatch(test_name, exp_err, err);

  result_held: assert property (@(posedge clk) disable iff (!rst)
      $past(err_valid && !err_ready) |-> (err_valid && err == $past(err)))
    else stop_run("result changed or dropped while err_ready was low");

  busy_while_pending: assert property (@(posedge clk) disable iff (!rst)
      err_valid |-> !req_ready)
    else stop_run("req_ready high while a result is pending");

  accept_after_result: assert property (@(posedge clk) disable iff (!rst)
      (req_valid && req_ready) |-> (n_acc == n_res))
    else stop_run("request accepted before the previous result was taken");

  result_per_request: assert property (@(posedge clk) disable iff (!rst)
      (err_valid && err_ready) |-> (n_acc == n_res + 1))
    else stop_run("result delivered without a matching request");

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  function automatic fx_t rand_unit();  // -1.0 up to 1.0
    logic [31:0] v;
    v = next_random();
    return fx_t'($signed(v[31:15]));
  endfunction

  function automatic fx_t rand_sample();  // about +-8.0
    logic [31:0] v;
    v = next_random();
    return fx_t'($signed(v[31:12]));
  endfunction

  function automatic dcm_t rand_dcm();
    dcm_t c;
    c.c11 = rand_unit();
    c.c12 = rand_unit();
    c.c13 = rand_unit();
    c.c21 = rand_unit();
    c.c22 = rand_unit();
    c.c23 = rand_unit();
    c.c31 = rand_unit();
    c.c32 = rand_unit();
    c.c33 = rand_unit();
    return c;
  endfunction

  task automatic run_request(input string name, input mag_req_t r, input int stall);
    @(posedge clk);
    #2;
    test_name = name;
    exp_err   = model(r);
    req       = r;
    req_valid = 1'b1;
    err_ready = (stall == 0);
    @(negedge clk);
    while (!req_ready)
      @(negedge clk);
    @(posedge clk);  // request taken
    #2;
    req_valid = 1'b0;
    n_sent++;
    @(negedge clk);
    while (!err_valid)
      @(negedge clk);
    if (stall > 0) begin
      repeat (stall) begin
        @(posedge clk);
        #2;
        req_valid = 1'b1;  // must wait for the result handshake
      end
      err_ready = 1'b1;
    end
    @(posedge clk);  // result taken
    #2;
    req_valid = 1'b0;
    err_ready = 1'b0;
  endtask

  initial begin
    mag_req_t    r;
    logic [31:0] v;
    int          stall;
    rst       = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    err_ready = 1'b0;
    lcg_state = 32'h3d56_ae59;
    test_name = "reset";
    exp_err   = '0;
    n_sent    = 0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b1;

    r         = '0;
    r.mag.x   = 32'sh0000_8000;   // 0.5
    r.mag.y   = -32'sh0000_4000;  // -0.25
    r.mag.z   = 32'sh0000_c000;   // 0.75
    r.dcm.c11 = ONE;
    r.dcm.c22 = ONE;
    r.dcm.c33 = ONE;
    run_request("identity", r, 0);

    for (int i = 0; i < N_RAND; i++) begin
      r.mag.x = rand_sample();
      r.mag.y = rand_sample();
      r.mag.z = rand_sample();
      r.dcm   = rand_dcm();
      stall   = 0;
      if (i % 4 == 3) begin  // every fourth result stalls
        v     = next_random();
        stall = int'(v[31:29]) + 1;
      end
      run_request($sformatf("random_%0d", i), r, stall);
    end

    r.mag = '0;  // x/0 path on all three axes
    r.dcm = rand_dcm();
    run_request("zero_sample", r, 2);

    if (n_res != n_sent)
      stop_run($sformatf("%0d requests sent but %0d results taken", n_sent, n_res));
    else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- project.f
mag_pkg.sv
fx_mac.sv
fx_sqrt.sv
fx_div.sv
mag_error_ctrl.sv
mag_error_top.sv
tb_mag_error.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mag_error -f project.f -o tb_mag_error

./obj_dir/tb_mag_error
